//--- src/decompressor_pkg.sv
// shared widths and sizes for the decompressor
// tag, token and parser state enums
package decompressor_pkg;

	localparam int BYTE_W     = 8;
	localparam int WORD_BYTES = 8;    // bytes per output word
	localparam int WORD_W     = 64;
	localparam int HIST_DEPTH = 1024; // history window in bytes
	localparam int HIST_AW    = 10;
	localparam int LEN_W      = 7;    // copy length up to 64
	localparam int OFF_W      = 16;
	localparam int CLEN_W     = 20;
	localparam int DLEN_W     = 20;
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AFULL = 12;   // leaves room for the source to stop

	// low two bits of a tag byte
	typedef enum logic [1:0] {
		TAG_LITERAL = 2'b00,
		TAG_COPY1   = 2'b01,
		TAG_COPY2   = 2'b10,
		TAG_COPY4   = 2'b11
	} tag_type_e;

	typedef enum logic {
		TOK_LIT  = 1'b0,
		TOK_COPY = 1'b1
	} token_kind_e;

	typedef enum logic [2:0] {
		PS_IDLE,
		PS_TAG,
		PS_OFF0,
		PS_OFF1,
		PS_LIT
	} parser_state_e;

endpackage

//--- src/token_if.sv
// token link from parser to copy engine
// valid/ready pair with literal and copy payload
`timescale 1ns/1ps

interface token_if import decompressor_pkg::*; ();

	logic              valid;
	logic              ready;
	token_kind_e       kind;
	logic [BYTE_W-1:0] lit_byte;
	logic [LEN_W-1:0]  copy_len;
	logic [OFF_W-1:0]  copy_off; // bytes back from the newest history byte

	modport parser (output valid, kind, lit_byte, copy_len, copy_off, input ready);
	modport engine (input valid, kind, lit_byte, copy_len, copy_off, output ready);

endinterface

//--- src/byte_fifo.sv
// input FIFO for compressed bytes
// registered read port and almost-full flag
`timescale 1ns/1ps

module byte_fifo import decompressor_pkg::*; (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic [BYTE_W-1:0] din_i,
	input  logic              wr_en_i,
	input  logic              rd_en_i,
	output logic [BYTE_W-1:0] dout_o,
	output logic              dout_valid_o,
	output logic              empty_o,
	output logic              almost_full_o
);

	logic [BYTE_W-1:0]             mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH):0]   fill;
	logic                          wr_ok;
	logic                          rd_ok;

	assign empty_o       = (fill == '0);
	assign almost_full_o = (fill >= FIFO_AFULL);
	assign wr_ok         = wr_en_i && (fill != FIFO_DEPTH); // drop writes when full
	assign rd_ok         = rd_en_i && !empty_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			fill         <= '0;
			dout_valid_o <= 1'b0;
		end else begin
			dout_valid_o <= rd_ok; // data shows one cycle after the read
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= din_i;
		end
		if (rd_ok) begin
			dout_o <= mem[rd_ptr];
		end
	end

endmodule

//--- src/token_parser.sv
// tag decoder, one byte at a time from the input FIFO
// emits one literal token per byte and one token per copy
`timescale 1ns/1ps

module token_parser import decompressor_pkg::*; (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              start_i,
	input  logic [CLEN_W-1:0] compression_length_i,
	input  logic [BYTE_W-1:0] fifo_data_i,
	input  logic              fifo_valid_i,
	input  logic              fifo_empty_i,
	output logic              fifo_rd_o,
	token_if.parser           tok
);

	parser_state_e     state;
	logic [CLEN_W-1:0] bytes_left; // compressed bytes still to read
	logic              rd_pend;    // read issued, data due this cycle
	logic [LEN_W-1:0]  lit_left;
	tag_type_e         tag_q;
	tag_type_e         tag_type;

	assign tag_type  = tag_type_e'(fifo_data_i[1:0]);
	assign fifo_rd_o = (state != PS_IDLE) && !fifo_empty_i && !rd_pend && !tok.valid
		&& (bytes_left != '0);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state      <= PS_IDLE;
			bytes_left <= '0;
			rd_pend    <= 1'b0;
			lit_left   <= '0;
			tag_q      <= TAG_LITERAL;
			tok.valid  <= 1'b0;
		end else if (start_i) begin
			state      <= PS_TAG;
			bytes_left <= compression_length_i;
			rd_pend    <= 1'b0;
			tok.valid  <= 1'b0;
		end else begin
			rd_pend <= fifo_rd_o;
			if (fifo_rd_o) begin
				bytes_left <= bytes_left - 1'b1;
			end
			if (tok.valid && tok.ready) begin
				tok.valid <= 1'b0;
			end
			if (fifo_valid_i) begin
				case (state)
					PS_TAG: begin
						tag_q <= tag_type;
						if (tag_type == TAG_LITERAL) begin
							lit_left <= LEN_W'(fifo_data_i[7:2]) + 1'b1;
							state    <= PS_LIT;
						end else begin
							state <= PS_OFF0;
						end
					end
					PS_OFF0: begin
						if (tag_q == TAG_COPY1) begin
							tok.valid <= 1'b1; // single offset byte done
							state     <= PS_TAG;
						end else begin
							state <= PS_OFF1;
						end
					end
					PS_OFF1: begin
						tok.valid <= 1'b1;
						state     <= PS_TAG;
					end
					PS_LIT: begin
						tok.valid <= 1'b1;
						lit_left  <= lit_left - 1'b1;
						if (lit_left == LEN_W'(1)) begin
							state <= PS_TAG;
						end
					end
					default: ;
				endcase
			end else if (state == PS_TAG && bytes_left == '0 && !rd_pend) begin
				state <= PS_IDLE; // whole stream consumed
			end
		end
	end

	// token payload, only written while no token waits
	always_ff @(posedge clk) begin
		if (fifo_valid_i) begin
			case (state)
				PS_TAG: begin
					tok.kind <= TOK_COPY;
					case (tag_type)
						TAG_COPY1: begin
							tok.copy_len <= LEN_W'(fifo_data_i[4:2]) + LEN_W'(4);
							tok.copy_off <= OFF_W'({fifo_data_i[7:5], 8'h00}); // offset bits 10:8
						end
						TAG_COPY2, TAG_COPY4: begin
							tok.copy_len <= LEN_W'(fifo_data_i[7:2]) + 1'b1;
							tok.copy_off <= '0;
						end
						default: ;
					endcase
				end
				PS_OFF0: tok.copy_off[BYTE_W-1:0] <= fifo_data_i;
				PS_OFF1: tok.copy_off[OFF_W-1:BYTE_W] <= fifo_data_i;
				PS_LIT: begin
					tok.kind     <= TOK_LIT;
					tok.lit_byte <= fifo_data_i;
				end
				default: ;
			endcase
		end
	end

endmodule

//--- src/copy_engine.sv
// expands tokens into a byte stream
// literals pass straight through, copies replay history one byte per cycle
`timescale 1ns/1ps

module copy_engine import decompressor_pkg::*; (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic [BYTE_W-1:0] hist_data_i,
	input  logic              byte_ready_i,
	output logic              hist_wr_o,
	output logic [BYTE_W-1:0] hist_wdata_o,
	output logic [OFF_W-1:0]  hist_back_o,
	output logic              byte_valid_o,
	output logic [BYTE_W-1:0] byte_data_o,
	token_if.engine           tok
);

	logic             busy;   // copy in progress
	logic [LEN_W-1:0] left_q; // copy bytes still to send
	logic [OFF_W-1:0] off_q;
	logic             lit_req;
	logic             copy_take;

	assign tok.ready = !busy && byte_ready_i;
	assign lit_req   = tok.valid && (tok.kind == TOK_LIT) && !busy;
	assign copy_take = tok.valid && tok.ready && (tok.kind == TOK_COPY);

	assign byte_valid_o = busy || lit_req;
	assign byte_data_o  = busy ? hist_data_i : tok.lit_byte;

	// every byte sent also goes into history
	assign hist_wr_o    = byte_valid_o && byte_ready_i;
	assign hist_wdata_o = byte_data_o;
	assign hist_back_o  = off_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy   <= 1'b0;
			left_q <= '0;
		end else if (copy_take) begin
			busy   <= 1'b1;
			left_q <= tok.copy_len;
		end else if (busy && byte_ready_i) begin
			left_q <= left_q - 1'b1;
			if (left_q == LEN_W'(1)) begin
				busy <= 1'b0; // last copy byte leaves now
			end
		end
	end

	always_ff @(posedge clk) begin
		if (copy_take) begin
			off_q <= tok.copy_off;
		end
	end

endmodule

//--- src/history_ram.sv
// byte history window with wrapping write pointer
// back-reference read relative to the newest byte
`timescale 1ns/1ps

module history_ram import decompressor_pkg::*; (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              start_i,
	input  logic              wr_en_i,
	input  logic [BYTE_W-1:0] wr_data_i,
	input  logic [OFF_W-1:0]  rd_back_i,
	output logic [BYTE_W-1:0] rd_data_o
);

	logic [BYTE_W-1:0]  mem [HIST_DEPTH];
	logic [HIST_AW-1:0] wr_ptr;
	logic [HIST_AW-1:0] rd_addr;

	assign rd_addr   = wr_ptr - rd_back_i[HIST_AW-1:0]; // wraps modulo depth
	assign rd_data_o = mem[rd_addr];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
		end else if (start_i) begin
			wr_ptr <= '0;
		end else if (wr_en_i) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

endmodule

//--- src/output_packer.sv
// gathers bytes into 64-bit words with a lane mask
// last word flag, output hold on wr_ready_i, done pulse
`timescale 1ns/1ps

module output_packer import decompressor_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  start_i,
	input  logic [DLEN_W-1:0]     decompression_length_i,
	input  logic                  byte_valid_i,
	input  logic [BYTE_W-1:0]     byte_data_i,
	input  logic                  wr_ready_i,
	output logic                  byte_ready_o,
	output logic [WORD_W-1:0]     data_o,
	output logic [WORD_BYTES-1:0] byte_valid_o,
	output logic                  valid_o,
	output logic                  last_o,
	output logic                  done_o
);

	logic [WORD_W-1:0]             word_q;
	logic [WORD_BYTES-1:0]         mask_q;
	logic [$clog2(WORD_BYTES)-1:0] lane_q; // next lane to fill
	logic [DLEN_W-1:0]             count_q;
	logic [DLEN_W-1:0]             dlen_q;
	logic [DLEN_W-1:0]             count_nxt;
	logic                          take;
	logic                          flush;
	logic                          final_byte;

	assign byte_ready_o = !valid_o; // no new bytes while a word waits
	assign take         = byte_valid_i && byte_ready_o;
	assign flush        = valid_o && wr_ready_i;
	assign count_nxt    = count_q + 1'b1;
	assign final_byte   = (count_nxt == dlen_q);
	assign byte_valid_o = mask_q;

	// unused lanes read as zero
	always_comb begin
		for (int i = 0; i < WORD_BYTES; i++) begin
			data_o[i*BYTE_W +: BYTE_W] = mask_q[i] ? word_q[i*BYTE_W +: BYTE_W] : '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mask_q  <= '0;
			lane_q  <= '0;
			count_q <= '0;
			dlen_q  <= '0;
			valid_o <= 1'b0;
			last_o  <= 1'b0;
			done_o  <= 1'b0;
		end else if (start_i) begin
			mask_q  <= '0;
			lane_q  <= '0;
			count_q <= '0;
			dlen_q  <= decompression_length_i;
			valid_o <= 1'b0;
			last_o  <= 1'b0;
			done_o  <= 1'b0;
		end else begin
			done_o <= flush && last_o;
			if (flush) begin
				valid_o <= 1'b0;
				last_o  <= 1'b0;
				mask_q  <= '0;
			end
			if (take) begin
				mask_q[lane_q] <= 1'b1;
				count_q        <= count_nxt;
				if ((&lane_q) || final_byte) begin // top lane filled or stream ends
					valid_o <= 1'b1;
					last_o  <= final_byte;
					lane_q  <= '0;
				end else begin
					lane_q <= lane_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			word_q[lane_q*BYTE_W +: BYTE_W] <= byte_data_i;
		end
	end

endmodule

//--- src/decompressor.sv
// byte-serial decompressor top level
// FIFO, parser, copy engine, history and packer
`timescale 1ns/1ps

module decompressor import decompressor_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic [BYTE_W-1:0]     data_i,
	input  logic                  valid_i,
	input  logic                  start_i,
	input  logic [CLEN_W-1:0]     compression_length_i,   // compressed bytes
	input  logic [DLEN_W-1:0]     decompression_length_i, // decompressed bytes
	input  logic                  wr_ready_i,
	output logic                  data_fifo_almostfull_o,
	output logic                  done_o,
	output logic                  last_o,
	output logic [WORD_W-1:0]     data_o,
	output logic [WORD_BYTES-1:0] byte_valid_o,
	output logic                  valid_o
);

	logic              fifo_rd;
	logic              fifo_valid;
	logic              fifo_empty;
	logic [BYTE_W-1:0] fifo_dout;
	logic              hist_wr;
	logic [BYTE_W-1:0] hist_wdata;
	logic [BYTE_W-1:0] hist_rdata;
	logic [OFF_W-1:0]  hist_back;
	logic              eng_valid;
	logic              eng_ready;
	logic [BYTE_W-1:0] eng_data;

	token_if i_token_if ();

	byte_fifo i_byte_fifo (
		.clk(clk), .arst_n_i(arst_n_i), .din_i(data_i), .wr_en_i(valid_i),
		.rd_en_i(fifo_rd), .dout_o(fifo_dout), .dout_valid_o(fifo_valid),
		.empty_o(fifo_empty), .almost_full_o(data_fifo_almostfull_o)
	);

	token_parser i_token_parser (
		.clk(clk), .arst_n_i(arst_n_i), .start_i(start_i),
		.compression_length_i(compression_length_i), .fifo_data_i(fifo_dout),
		.fifo_valid_i(fifo_valid), .fifo_empty_i(fifo_empty), .fifo_rd_o(fifo_rd),
		.tok(i_token_if.parser)
	);

	copy_engine i_copy_engine (
		.clk(clk), .arst_n_i(arst_n_i), .hist_data_i(hist_rdata), .byte_ready_i(eng_ready),
		.hist_wr_o(hist_wr), .hist_wdata_o(hist_wdata), .hist_back_o(hist_back),
		.byte_valid_o(eng_valid), .byte_data_o(eng_data), .tok(i_token_if.engine)
	);

	history_ram i_history_ram (
		.clk(clk), .arst_n_i(arst_n_i), .start_i(start_i), .wr_en_i(hist_wr),
		.wr_data_i(hist_wdata), .rd_back_i(hist_back), .rd_data_o(hist_rdata)
	);

	output_packer i_output_packer (
		.clk(clk), .arst_n_i(arst_n_i), .start_i(start_i),
		.decompression_length_i(decompression_length_i), .byte_valid_i(eng_valid),
		.byte_data_i(eng_data), .wr_ready_i(wr_ready_i), .byte_ready_o(eng_ready),
		.data_o(data_o), .byte_valid_o(byte_valid_o), .valid_o(valid_o),
		.last_o(last_o), .done_o(done_o)
	);

endmodule

//--- verification/tb_clk_gen.sv
// clock and reset source for the testbench
// 8 ns clock, reset held low for four cycles
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic arst_n_o
);

	localparam int PERIOD_NS = 8;

	initial begin
		clk_o    = 1'b0;
		arst_n_o = 1'b0;
		repeat (4) @(posedge clk_o);
		#1 arst_n_o = 1'b1; // release clear of the edge
	end

	always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- verification/decompressor_props.sv
// concurrent checks on the packer word outputs
// hold under stall, non-empty mask, single-cycle done
`timescale 1ns/1ps

module decompressor_props import decompressor_pkg::*; (
	input logic                  clk,
	input logic                  arst_n_i,
	input logic                  valid_i,
	input logic                  wr_ready_i,
	input logic [WORD_W-1:0]     data_i,
	input logic [WORD_BYTES-1:0] mask_i,
	input logic                  done_i
);

	int fail_cnt = 0; // failed assertions so far

	// a stalled word keeps its data and mask
	hold_stalled: assert property (@(posedge clk) disable iff (!arst_n_i)
		valid_i && !wr_ready_i |=> valid_i && $stable(data_i) && $stable(mask_i))
		else begin
			fail_cnt++;
			$error("output word changed while stalled");
		end

	mask_not_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
		valid_i |-> (mask_i != '0))
		else begin
			fail_cnt++;
			$error("valid word with empty byte mask");
		end

	done_single: assert property (@(posedge clk) disable iff (!arst_n_i)
		done_i |=> !done_i)
		else begin
			fail_cnt++;
			$error("done pulse longer than one cycle");
		end

endmodule

bind output_packer decompressor_props i_decompressor_props (
	.clk(clk), .arst_n_i(arst_n_i), .valid_i(valid_o), .wr_ready_i(wr_ready_i),
	.data_i(data_o), .mask_i(byte_valid_o), .done_i(done_o)
);

//--- verification/tb_decompressor.sv
// testbench for the decompressor
// token lists, stream encoder, reference decoder, word compare, timeout
`timescale 1ns/1ps

module tb_decompressor import decompressor_pkg::*; ();

	localparam int TO_PER_BYTE = 40;  // timeout cycles per output byte
	localparam int TO_MARGIN   = 500;

	logic                  clk;
	logic                  arst_n_i;
	logic [BYTE_W-1:0]     data_i;
	logic                  valid_i;
	logic                  start_i;
	logic [CLEN_W-1:0]     compression_length_i;
	logic [DLEN_W-1:0]     decompression_length_i;
	logic                  wr_ready_i;
	logic                  data_fifo_almostfull_o;
	logic                  done_o;
	logic                  last_o;
	logic [WORD_W-1:0]     data_o;
	logic [WORD_BYTES-1:0] byte_valid_o;
	logic                  valid_o;

	integer     seed = 87187;
	int         tk_type[$];  // 0 literal run, 1 one-byte offset copy, 2 two-byte offset copy
	int         tk_len[$];
	int         tk_off[$];
	logic [7:0] lit_q[$];
	logic [7:0] comp_q[$];   // encoded stream
	logic [7:0] exp_q[$];    // expected output bytes
	int         produced = 0;
	int         out_idx = 0; // next expected byte
	int         done_cnt = 0;
	int         cyc = 0;
	int         deadline = 1000;
	int         fill_model = 0; // bytes the input FIFO should hold

	tb_clk_gen i_tb_clk_gen (.clk_o(clk), .arst_n_o(arst_n_i));

	decompressor i_decompressor (.*);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch at time %0t: %s got 0x%0h, expected 0x%0h",
				$time, name, got, exp));
		end
	endtask

	task automatic add_literals(input int n);
		tk_type.push_back(0);
		tk_len.push_back(n);
		tk_off.push_back(0);
		repeat (n) lit_q.push_back(8'($random(seed)));
		produced += n;
	endtask

	task automatic add_copy(input int kind, input int len, input int off);
		tk_type.push_back(kind);
		tk_len.push_back(len);
		tk_off.push_back(off);
		produced += len;
	endtask

	task automatic add_random_token();
		int r;
		int lim;
		int off;
		r   = $random(seed) & 3;
		lim = (produced < 1000) ? produced : 1000;
		off = 1 + (($random(seed) & 32'h7fff_ffff) % lim);
		if (r == 0) begin
			add_literals(1 + ($random(seed) & 31));
		end else if (r == 1) begin
			add_copy(1, 4 + ($random(seed) & 7), off);
		end else begin
			add_copy(2, 1 + ($random(seed) & 63), off);
		end
	endtask

	// plain LZ77 expansion of the token list
	function automatic void ref_decode();
		int li;
		li = 0;
		exp_q.delete();
		foreach (tk_type[t]) begin
			for (int j = 0; j < tk_len[t]; j++) begin
				if (tk_type[t] == 0) begin
					exp_q.push_back(lit_q[li]);
					li++;
				end else begin
					exp_q.push_back(exp_q[exp_q.size() - tk_off[t]]); // may overlap itself
				end
			end
		end
	endfunction

	function automatic void encode_stream();
		int li;
		li = 0;
		comp_q.delete();
		foreach (tk_type[t]) begin
			case (tk_type[t])
				0: begin
					comp_q.push_back({6'(tk_len[t] - 1), 2'b00});
					repeat (tk_len[t]) begin
						comp_q.push_back(lit_q[li]);
						li++;
					end
				end
				1: begin
					comp_q.push_back({3'(tk_off[t] >> 8), 3'(tk_len[t] - 4), 2'b01});
					comp_q.push_back(8'(tk_off[t]));
				end
				default: begin
					comp_q.push_back({6'(tk_len[t] - 1), 2'b10});
					comp_q.push_back(8'(tk_off[t])); // offset low byte first
					comp_q.push_back(8'(tk_off[t] >> 8));
				end
			endcase
		end
	endfunction

	task automatic run_stream();
		ref_decode();
		encode_stream();
		out_idx  = 0;
		done_cnt = 0;
		deadline = cyc + TO_PER_BYTE * exp_q.size() + TO_MARGIN;
		compression_length_i   = CLEN_W'(comp_q.size());
		decompression_length_i = DLEN_W'(exp_q.size());
		start_i = 1'b1;
		@(posedge clk);
		#1 start_i = 1'b0;
		foreach (comp_q[k]) begin
			while (data_fifo_almostfull_o || ($random(seed) & 3) == 0) begin
				valid_i = 1'b0; // gap or FIFO nearly full
				@(posedge clk);
				#1;
			end
			valid_i = 1'b1;
			data_i  = comp_q[k];
			@(posedge clk);
			#1;
		end
		valid_i = 1'b0;
		while (done_cnt == 0) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);
		#1;
		check_value("done_o pulse count", 64'(done_cnt), 64'd1);
		tk_type.delete();
		tk_len.delete();
		tk_off.delete();
		lit_q.delete();
		produced = 0;
	endtask

	always @(posedge clk) begin
		#1 wr_ready_i = ($random(seed) & 3) != 0; // low about one cycle in four
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc > deadline) begin
			fail_run($sformatf("Timeout: stream not finished after %0d cycles", cyc));
		end
	end

	// input FIFO level from writes and reads, flag compared every cycle
	always @(negedge clk) begin : fifo_level
		int wr;
		int rd;
		if (arst_n_i) begin
			check_value("data_fifo_almostfull_o", 64'(data_fifo_almostfull_o),
				64'(fill_model >= FIFO_AFULL));
			wr = (valid_i && fill_model < FIFO_DEPTH) ? 1 : 0;
			rd = (i_decompressor.fifo_rd && fill_model > 0) ? 1 : 0;
			fill_model += wr - rd;
		end
	end

	// accepted words are checked mid-cycle
	always @(negedge clk) begin : compare_words
		logic       exp_on;
		logic [7:0] exp_byte;
		if (arst_n_i && valid_o && wr_ready_i) begin
			if (out_idx >= exp_q.size()) begin
				fail_run("Output word arrived after the whole stream was delivered");
			end
			for (int i = 0; i < WORD_BYTES; i++) begin
				exp_on   = (out_idx + i < exp_q.size());
				exp_byte = exp_on ? exp_q[out_idx + i] : 8'h00;
				check_value($sformatf("byte_valid_o[%0d]", i), 64'(byte_valid_o[i]), 64'(exp_on));
				check_value($sformatf("data_o lane %0d", i), 64'(data_o[i*BYTE_W +: BYTE_W]),
					64'(exp_byte));
			end
			check_value("last_o", 64'(last_o), 64'(out_idx + WORD_BYTES >= exp_q.size()));
			out_idx += WORD_BYTES;
		end
		if (arst_n_i && done_o) begin
			if (out_idx < exp_q.size()) begin
				fail_run("done_o pulsed before the last word was accepted");
			end
			done_cnt++;
		end
	end

	initial begin
		data_i                 = '0;
		valid_i                = 1'b0;
		start_i                = 1'b0;
		compression_length_i   = '0;
		decompression_length_i = '0;
		wr_ready_i             = 1'b0;
		wait (arst_n_i === 1'b1);
		@(posedge clk);
		#1;
		// literals only, last word half full
		add_literals(13);
		add_literals(7);
		run_stream();
		// one-byte offset copies, no overlap, 40 bytes
		add_literals(16);
		add_copy(1, 8, 16);
		add_copy(1, 5, 9);
		add_copy(1, 11, 20);
		run_stream();
		// overlapping runs
		add_literals(1);
		add_copy(1, 11, 1);
		add_literals(3);
		add_copy(1, 10, 3);
		add_copy(2, 64, 2);
		add_copy(2, 7, 5);
		run_stream();
		// far back-references, 1129 bytes
		repeat (17) add_literals(60);
		add_copy(2, 64, 1000);
		add_copy(2, 33, 517);
		add_copy(1, 7, 1023);
		add_literals(5);
		run_stream();
		// random token mix
		add_literals(8);
		repeat (60) add_random_token();
		run_stream();
		if (i_decompressor.i_output_packer.i_decompressor_props.fail_cnt == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			fail_run("Assertion failures on the packer outputs");
		end
	end

endmodule

//--- flist.f
src/decompressor_pkg.sv
src/token_if.sv
src/byte_fifo.sv
src/token_parser.sv
src/copy_engine.sv
src/history_ram.sv
src/output_packer.sv
src/decompressor.sv
verification/tb_clk_gen.sv
verification/decompressor_props.sv
verification/tb_decompressor.sv

//--- Makefile
SIM     = verilator
TOP     = tb_decompressor
FLIST   = flist.f
FLAGS   = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR = obj_dir
LOG     = sim.log
PASS    = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
